/* sim.f */
hdl/rv_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/rv_decoder.sv
hdl/rv_gpr.sv
hdl/rv_branch_unit.sv
hdl/id_stage.sv
test/id_stage_props.sv
test/tb_clock_gen.sv
test/id_stage_tb.sv

/* test/id_stage_tb.sv */
// directed testbench for the rv64i decode stage
`default_nettype none

module id_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SETTLE         = 10;              // ns after the falling edge
  localparam int RUN_CYCLES     = 400;             // rough length of all tests
  localparam int TIMEOUT_CYCLES = 5 * RUN_CYCLES;

  logic        clk;
  logic        rst;
  logic        fs_valid;
  logic [31:0] fs_inst;
  logic [63:0] fs_pc;
  logic        ws_gpr_wen;
  logic [4:0]  ws_gpr_waddr;
  logic [63:0] ws_gpr_wdata;
  logic [63:0] es_rs1data;
  logic [63:0] es_rs2data;
  logic [63:0] es_imm;
  logic [63:0] es_pc;
  logic [4:0]  es_alu_op;
  logic        es_src1_sel;
  logic [1:0]  es_src2_sel;
  logic [4:0]  es_rd;
  logic        es_gpr_wen;
  logic        es_mem_ren;
  logic        es_mem_wen;
  logic [2:0]  es_mem_op;
  logic        es_invalid;
  logic        br_sel;
  logic [63:0] br_target;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [31:0] lfsr_state = 32'd10498;

  tb_clock_gen u_clk (.o_clk(clk), .o_rst(rst));

  id_stage DUT (
    .i_clk (clk), .i_rst (rst),
    .i_fs_valid (fs_valid), .i_fs_inst (fs_inst), .i_fs_pc (fs_pc),
    .i_ws_gpr_wen (ws_gpr_wen), .i_ws_gpr_waddr (ws_gpr_waddr),
    .i_ws_gpr_wdata (ws_gpr_wdata),
    .o_es_rs1data (es_rs1data), .o_es_rs2data (es_rs2data),
    .o_es_imm (es_imm), .o_es_pc (es_pc), .o_es_alu_op (es_alu_op),
    .o_es_alu_src1_sel (es_src1_sel), .o_es_alu_src2_sel (es_src2_sel),
    .o_es_rd (es_rd), .o_es_gpr_wen (es_gpr_wen), .o_es_mem_ren (es_mem_ren),
    .o_es_mem_wen (es_mem_wen), .o_es_mem_op (es_mem_op),
    .o_es_invalid (es_invalid), .o_br_sel (br_sel), .o_br_target (br_target)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // galois lfsr with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[62:0], lfsr_step()};
    end
    return v;
  endfunction

  // instruction encoders over the format union
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    rv_isa_pkg::rv_inst_u w;
    w.r = '{f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    rv_isa_pkg::rv_inst_u w;
    w.i = '{imm, rs1, f3, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    rv_isa_pkg::rv_inst_u w;
    w.s = '{imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OPC_STORE};
    return w;
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    rv_isa_pkg::rv_inst_u w;
    w.b = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    rv_isa_pkg::rv_inst_u w;
    w.u = '{imm, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    rv_isa_pkg::rv_inst_u w;
    w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
    return w;
  endfunction

  // reference branch rule from the isa
  function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a, b);
    case (f3)
      rv_isa_pkg::F3_BEQ:  return a == b;
      rv_isa_pkg::F3_BNE:  return a != b;
      rv_isa_pkg::F3_BLT:  return $signed(a) < $signed(b);
      rv_isa_pkg::F3_BGE:  return $signed(a) >= $signed(b);
      rv_isa_pkg::F3_BLTU: return a < b;
      default:             return a >= b;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] actual, expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic check_ctrl(input logic [4:0] alu, input logic s1, input logic [1:0] s2,
                            input logic gwen, mren, mwen);
    check("o_es_alu_op", es_alu_op, alu);
    check("o_es_alu_src1_sel", es_src1_sel, s1);
    check("o_es_alu_src2_sel", es_src2_sel, s2);
    check("o_es_gpr_wen", es_gpr_wen, gwen);
    check("o_es_mem_ren", es_mem_ren, mren);
    check("o_es_mem_wen", es_mem_wen, mwen);
  endtask

  task automatic check_enables_low();
    check("o_es_gpr_wen", es_gpr_wen, 0);
    check("o_es_mem_ren", es_mem_ren, 0);
    check("o_es_mem_wen", es_mem_wen, 0);
    check("o_br_sel", br_sel, 0);
  endtask

  task automatic present_inst(input logic valid, input logic [31:0] inst,
                              input logic [63:0] pc);
    @(negedge clk);
    fs_valid   = valid;
    fs_inst    = inst;
    fs_pc      = pc;
    ws_gpr_wen = 1'b0;
    #(SETTLE);  // combinational outputs settle well before the rising edge
  endtask

  task automatic write_gpr(input logic [4:0] addr, input logic [63:0] data);
    @(negedge clk);
    fs_valid     = 1'b0;
    ws_gpr_wen   = 1'b1;
    ws_gpr_waddr = addr;
    ws_gpr_wdata = data;
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %-16s done, %0d errors", name, errors - start);
  endtask

  task automatic test_reset_state();
    int start;
    start = errors;
    for (int k = 0; k < 32; k += 2) begin
      present_inst(1'b1, enc_r(7'd0, 5'(k + 1), 5'(k), 3'b000, 5'd1), 64'h1000);
      check("o_es_rs1data", es_rs1data, '0);
      check("o_es_rs2data", es_rs2data, '0);
    end
    write_gpr(5'd0, rand_bits(64));
    present_inst(1'b1, enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd1), 64'h1000);
    check("o_es_rs1data", es_rs1data, '0);
    check("o_es_rs2data", es_rs2data, '0);
    // same-cycle write and read of x7 still sees the old value
    @(negedge clk);
    fs_valid     = 1'b1;
    fs_inst      = enc_r(7'd0, 5'd7, 5'd7, 3'b000, 5'd1);
    ws_gpr_wen   = 1'b1;
    ws_gpr_waddr = 5'd7;
    ws_gpr_wdata = rand_bits(64);
    #(SETTLE);
    check("o_es_rs1data", es_rs1data, '0);
    report_test("reset_state", start);
  endtask

  task automatic test_gpr_write_read();
    int          start;
    logic [63:0] value;
    logic [4:0]  rd;
    start = errors;
    for (int k = 1; k < 32; k++) begin
      value = rand_bits(64);
      rd    = 5'(rand_bits(5));
      write_gpr(5'(k), value);
      present_inst(1'b1, enc_r(7'd0, 5'(k), 5'(k), 3'b000, rd), 64'h2000);
      check("o_es_rs1data", es_rs1data, value);
      check("o_es_rs2data", es_rs2data, value);
      check("o_es_gpr_wen", es_gpr_wen, 1);
      check("o_es_rd", es_rd, rd);
    end
    report_test("gpr_write_read", start);
  endtask

  task automatic test_alu_decode();
    int          start;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [2:0]  f3;
    logic [63:0] pc;
    start = errors;
    pc = 64'h3000;
    present_inst(1'b1, enc_r(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1), pc);
    check_ctrl(id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SRC1_RS1, id_ctrl_pkg::SRC2_RS2, 1, 0, 0);
    check("o_es_pc", es_pc, pc);
    present_inst(1'b1, enc_r(7'b0100000, 5'd3, 5'd2, 3'b000, 5'd1), pc);
    check_ctrl(id_ctrl_pkg::ALU_SUB, id_ctrl_pkg::SRC1_RS1, id_ctrl_pkg::SRC2_RS2, 1, 0, 0);
    present_inst(1'b1, enc_r(7'b0100000, 5'd3, 5'd2, 3'b101, 5'd1), pc);
    check_ctrl(id_ctrl_pkg::ALU_SRA, id_ctrl_pkg::SRC1_RS1, id_ctrl_pkg::SRC2_RS2, 1, 0, 0);
    for (int n = 0; n < 4; n++) begin
      imm12 = 12'(rand_bits(12));
      imm20 = 20'(rand_bits(20));
      f3    = 3'(rand_bits(3));
      present_inst(1'b1, enc_i(imm12, 5'd4, 3'b110, 5'd9, rv_isa_pkg::OPC_OP_IMM), pc);
      check_ctrl(id_ctrl_pkg::ALU_OR, id_ctrl_pkg::SRC1_RS1, id_ctrl_pkg::SRC2_IMM, 1, 0, 0);
      check("o_es_imm", es_imm, {{52{imm12[11]}}, imm12});
      present_inst(1'b1, enc_u(imm20, 5'd9, rv_isa_pkg::OPC_LUI), pc);
      check_ctrl(id_ctrl_pkg::ALU_COPY2, id_ctrl_pkg::SRC1_RS1, id_ctrl_pkg::SRC2_IMM, 1, 0, 0);
      check("o_es_imm", es_imm, {{32{imm20[19]}}, imm20, 12'h000});
      present_inst(1'b1, enc_u(imm20, 5'd9, rv_isa_pkg::OPC_AUIPC), pc);
      check_ctrl(id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SRC1_PC, id_ctrl_pkg::SRC2_IMM, 1, 0, 0);
      check("o_es_imm", es_imm, {{32{imm20[19]}}, imm20, 12'h000});
      present_inst(1'b1, enc_i(imm12, 5'd4, f3, 5'd9, rv_isa_pkg::OPC_LOAD), pc);
      check_ctrl(id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SRC1_RS1, id_ctrl_pkg::SRC2_IMM, 1, 1, 0);
      check("o_es_mem_op", es_mem_op, f3);
      check("o_es_imm", es_imm, {{52{imm12[11]}}, imm12});
      present_inst(1'b1, enc_s(imm12, 5'd5, 5'd4, f3), pc);
      check_ctrl(id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SRC1_RS1, id_ctrl_pkg::SRC2_IMM, 0, 0, 1);
      check("o_es_mem_op", es_mem_op, f3);
      check("o_es_imm", es_imm, {{52{imm12[11]}}, imm12});
    end
    report_test("alu_decode", start);
  endtask

  task automatic test_branches();
    int          start;
    logic [63:0] val [1:4];
    logic [4:0]  ra [5];
    logic [4:0]  rb [5];
    logic [2:0]  f3s [6];
    logic [12:0] imm13;
    logic [63:0] pc;
    start = errors;
    val = '{64'd5, 64'd5, 64'hFFFF_FFFF_FFFF_FFFD, 64'd7};  // -3 is signed-less and unsigned-greater
    ra  = '{5'd1, 5'd3, 5'd4, 5'd1, 5'd4};
    rb  = '{5'd2, 5'd4, 5'd3, 5'd4, 5'd1};
    f3s = '{rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE, rv_isa_pkg::F3_BLT,
            rv_isa_pkg::F3_BGE, rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU};
    for (int k = 1; k <= 4; k++) begin
      write_gpr(5'(k), val[k]);
    end
    foreach (f3s[f]) begin
      foreach (ra[p]) begin
        imm13 = {12'(rand_bits(12)), 1'b0};
        pc    = rand_bits(62) << 2;
        present_inst(1'b1, enc_b(imm13, rb[p], ra[p], f3s[f]), pc);
        check("o_br_sel", br_sel, branch_taken(f3s[f], val[ra[p]], val[rb[p]]));
        check("o_br_target", br_target, pc + {{51{imm13[12]}}, imm13});
        check("o_es_gpr_wen", es_gpr_wen, 0);
      end
    end
    report_test("branches", start);
  endtask

  task automatic test_jumps();
    int          start;
    logic [20:0] imm21;
    logic [11:0] imm12;
    logic [4:0]  rd;
    logic [63:0] pc;
    logic [63:0] base;
    logic [63:0] target;
    start = errors;
    for (int n = 0; n < 3; n++) begin
      imm21 = {20'(rand_bits(20)), 1'b0};
      rd    = 5'(rand_bits(5));
      pc    = rand_bits(62) << 2;
      present_inst(1'b1, enc_j(imm21, rd), pc);
      check("o_br_sel", br_sel, 1);
      check("o_br_target", br_target, pc + {{43{imm21[20]}}, imm21});
      check_ctrl(id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SRC1_PC, id_ctrl_pkg::SRC2_FOUR, 1, 0, 0);
      check("o_es_rd", es_rd, rd);
      base  = rand_bits(64);
      imm12 = 12'(rand_bits(12));
      write_gpr(5'd6, base);
      present_inst(1'b1, enc_i(imm12, 5'd6, 3'b000, rd, rv_isa_pkg::OPC_JALR), pc);
      target    = base + {{52{imm12[11]}}, imm12};
      target[0] = 1'b0;
      check("o_br_sel", br_sel, 1);
      check("o_br_target", br_target, target);
      check_ctrl(id_ctrl_pkg::ALU_ADD, id_ctrl_pkg::SRC1_PC, id_ctrl_pkg::SRC2_FOUR, 1, 0, 0);
    end
    report_test("jumps", start);
  endtask

  task automatic test_invalid_and_idle();
    int          start;
    logic [31:0] insts [6];
    start = errors;
    // system and op-imm-32 are outside the decoded set
    present_inst(1'b1, {25'(rand_bits(25)), 7'b1110011}, 64'h4000);
    check("o_es_invalid", es_invalid, 1);
    check_enables_low();
    present_inst(1'b1, {25'(rand_bits(25)), 7'b0011011}, 64'h4000);
    check("o_es_invalid", es_invalid, 1);
    check_enables_low();
    insts = '{enc_j(21'h00100, 5'd1), enc_b(13'h0040, 5'd2, 5'd1, rv_isa_pkg::F3_BEQ),
              enc_i(12'h010, 5'd1, 3'b011, 5'd2, rv_isa_pkg::OPC_LOAD),
              enc_s(12'h010, 5'd2, 5'd1, 3'b011),
              enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd3), 32'h0000_0073};
    foreach (insts[k]) begin
      present_inst(1'b0, insts[k], 64'h5000);
      check("o_es_invalid", es_invalid, 0);
      check_enables_low();
    end
    report_test("invalid_and_idle", start);
  endtask

  initial begin
    fs_valid     = 1'b0;
    fs_inst      = '0;
    fs_pc        = '0;
    ws_gpr_wen   = 1'b0;
    ws_gpr_waddr = '0;
    ws_gpr_wdata = '0;
    wait (rst == 1'b0);
    test_reset_state();
    test_gpr_write_read();
    test_alu_decode();
    test_branches();
    test_jumps();
    test_invalid_and_idle();
    errors = errors + DUT.u_props.fail_count;  // bound assertion failures
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
// testbench clock and power-on reset source, 40 ns period
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 20;

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // two rising edges in reset, released on a falling edge
  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

/* test/id_stage_props.sv */
// concurrent checks on the decode stage bound into id_stage
`default_nettype none

module id_stage_props (
  input logic                                 i_clk,
  input logic                                 i_rst,
  input logic                                 i_fs_valid,
  input logic                                 i_gpr_wen,
  input logic                                 i_mem_ren,
  input logic                                 i_mem_wen,
  input logic                                 i_invalid,
  input logic                                 i_br_sel,
  input logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  i_rs1,
  input logic [id_ctrl_pkg::XLEN-1:0]         i_rs1data,
  input logic                                 i_jen,
  input logic [id_ctrl_pkg::XLEN-1:0]         i_br_target
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // failed assertions so far

  // an idle slot must not fire anything downstream
  idle_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
    !i_fs_valid |-> !(i_gpr_wen | i_mem_ren | i_mem_wen | i_invalid | i_br_sel))
    else begin
      fail_count++;
      $error("enable output high while i_fs_valid is low");
    end

  x0_reads_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rs1 == '0) |-> (i_rs1data == '0))
    else begin
      fail_count++;
      $error("rs1 data not zero for x0");
    end

  jump_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    i_jen |-> !i_br_target[0])
    else begin
      fail_count++;
      $error("jump target has bit 0 set");
    end

endmodule

bind id_stage id_stage_props u_props (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_fs_valid  (i_fs_valid),
  .i_gpr_wen   (o_es_gpr_wen),
  .i_mem_ren   (o_es_mem_ren),
  .i_mem_wen   (o_es_mem_wen),
  .i_invalid   (o_es_invalid),
  .i_br_sel    (o_br_sel),
  .i_rs1       (rs1),
  .i_rs1data   (o_es_rs1data),
  .i_jen       (jen),
  .i_br_target (o_br_target)
);

`default_nettype wire

/* hdl/id_stage.sv */
// decode stage top level wiring the decoder, register file and branch unit
`default_nettype none

module id_stage (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  // from fetch
  input  logic                                 i_fs_valid,
  input  logic [rv_isa_pkg::INST_WD-1:0]       i_fs_inst,
  input  logic [id_ctrl_pkg::XLEN-1:0]         i_fs_pc,
  // from write-back
  input  logic                                 i_ws_gpr_wen,
  input  logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  i_ws_gpr_waddr,
  input  logic [id_ctrl_pkg::XLEN-1:0]         i_ws_gpr_wdata,
  // to execute
  output logic [id_ctrl_pkg::XLEN-1:0]         o_es_rs1data,
  output logic [id_ctrl_pkg::XLEN-1:0]         o_es_rs2data,
  output logic [id_ctrl_pkg::XLEN-1:0]         o_es_imm,
  output logic [id_ctrl_pkg::XLEN-1:0]         o_es_pc,
  output logic [id_ctrl_pkg::ALU_OP_WD-1:0]    o_es_alu_op,
  output logic                                 o_es_alu_src1_sel,
  output logic [1:0]                           o_es_alu_src2_sel,
  output logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  o_es_rd,
  output logic                                 o_es_gpr_wen,
  output logic                                 o_es_mem_ren,
  output logic                                 o_es_mem_wen,
  output logic [id_ctrl_pkg::MEM_OP_WD-1:0]    o_es_mem_op,
  output logic                                 o_es_invalid,
  // redirect to fetch
  output logic                                 o_br_sel,
  output logic [id_ctrl_pkg::XLEN-1:0]         o_br_target
);

  logic [id_ctrl_pkg::GPR_ADDR_WD-1:0] rs1;
  logic [id_ctrl_pkg::GPR_ADDR_WD-1:0] rs2;
  logic                                bren;    // conditional branch
  logic                                jen;     // jal or jalr
  logic                                jalr;
  logic [2:0]                          brfunc;

  assign o_es_pc = i_fs_pc;

  rv_decoder u_decoder (
    .i_valid        (i_fs_valid),
    .i_inst         (i_fs_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_es_rd),
    .o_imm          (o_es_imm),
    .o_bren         (bren),
    .o_jen          (jen),
    .o_jalr         (jalr),
    .o_brfunc       (brfunc),
    .o_alu_op       (o_es_alu_op),
    .o_alu_src1_sel (o_es_alu_src1_sel),
    .o_alu_src2_sel (o_es_alu_src2_sel),
    .o_gpr_wen      (o_es_gpr_wen),
    .o_mem_ren      (o_es_mem_ren),
    .o_mem_wen      (o_es_mem_wen),
    .o_mem_op       (o_es_mem_op),
    .o_invalid      (o_es_invalid)
  );

  rv_gpr u_gprs (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (o_es_rs1data),
    .o_rdata2 (o_es_rs2data),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata)
  );

  rv_branch_unit u_bru (
    .i_rs1data   (o_es_rs1data),
    .i_rs2data   (o_es_rs2data),
    .i_pc        (i_fs_pc),
    .i_imm       (o_es_imm),
    .i_bren      (bren),
    .i_jen       (jen),
    .i_jalr      (jalr),
    .i_brfunc    (brfunc),
    .o_br_sel    (o_br_sel),
    .o_br_target (o_br_target)
  );

endmodule

`default_nettype wire

/* hdl/rv_branch_unit.sv */
// branch unit, resolves the branch condition and the redirect target
`default_nettype none

module rv_branch_unit (
  input  logic [id_ctrl_pkg::XLEN-1:0]  i_rs1data,
  input  logic [id_ctrl_pkg::XLEN-1:0]  i_rs2data,
  input  logic [id_ctrl_pkg::XLEN-1:0]  i_pc,
  input  logic [id_ctrl_pkg::XLEN-1:0]  i_imm,
  input  logic                          i_bren,
  input  logic                          i_jen,
  input  logic                          i_jalr,
  input  logic [2:0]                    i_brfunc,
  output logic                          o_br_sel,
  output logic [id_ctrl_pkg::XLEN-1:0]  o_br_target
);

  logic                         eq;
  logic                         lt;      // signed
  logic                         ltu;     // unsigned
  logic                         taken;
  logic [id_ctrl_pkg::XLEN-1:0] pc_rel;
  logic [id_ctrl_pkg::XLEN-1:0] reg_rel;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_brfunc)
      rv_isa_pkg::F3_BEQ:  taken = eq;
      rv_isa_pkg::F3_BNE:  taken = ~eq;
      rv_isa_pkg::F3_BLT:  taken = lt;
      rv_isa_pkg::F3_BGE:  taken = ~lt;
      rv_isa_pkg::F3_BLTU: taken = ltu;
      rv_isa_pkg::F3_BGEU: taken = ~ltu;
      default:             taken = 1'b0;  // 010/011 are not branches
    endcase
  end

  assign pc_rel  = i_pc + i_imm;
  assign reg_rel = i_rs1data + i_imm;

  // jumps always redirect
  assign o_br_sel = i_jen | (i_bren & taken);

  // jalr target drops bit 0
  assign o_br_target = (i_jen & i_jalr)
                     ? {reg_rel[id_ctrl_pkg::XLEN-1:1], 1'b0}
                     : pc_rel;

endmodule

`default_nettype wire

/* hdl/rv_gpr.sv */
// general register file, 32 x xlen, two combinational reads and one write
`default_nettype none

module rv_gpr (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  // read ports
  input  logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  i_raddr1,
  input  logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  i_raddr2,
  output logic [id_ctrl_pkg::XLEN-1:0]         o_rdata1,
  output logic [id_ctrl_pkg::XLEN-1:0]         o_rdata2,
  // write port from write-back
  input  logic                                 i_wen,
  input  logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  i_waddr,
  input  logic [id_ctrl_pkg::XLEN-1:0]         i_wdata
);

  // x0 has no storage
  logic [id_ctrl_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int k = 1; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, a same-cycle write shows up next cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

/* hdl/rv_decoder.sv */
// rv64i instruction decoder: register addresses, immediate and control fields
`default_nettype none

module rv_decoder (
  input  logic                                 i_valid,
  input  rv_isa_pkg::rv_inst_u                 i_inst,
  output logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  o_rs1,
  output logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  o_rs2,
  output logic [id_ctrl_pkg::GPR_ADDR_WD-1:0]  o_rd,
  output logic [id_ctrl_pkg::XLEN-1:0]         o_imm,
  output logic                                 o_bren,
  output logic                                 o_jen,
  output logic                                 o_jalr,
  output logic [2:0]                           o_brfunc,
  output logic [id_ctrl_pkg::ALU_OP_WD-1:0]    o_alu_op,
  output logic                                 o_alu_src1_sel,
  output logic [1:0]                           o_alu_src2_sel,
  output logic                                 o_gpr_wen,
  output logic                                 o_mem_ren,
  output logic                                 o_mem_wen,
  output logic [id_ctrl_pkg::MEM_OP_WD-1:0]    o_mem_op,
  output logic                                 o_invalid
);

  logic [31:0]                         imm32;   // sign-extended to 32 first
  logic [id_ctrl_pkg::ALU_OP_WD-1:0]   alu_f3;  // alu code from funct3 alone
  logic                                bren;
  logic                                jen;
  logic                                jalr;
  logic                                gpr_wen;
  logic                                mem_ren;
  logic                                mem_wen;
  logic                                known;

  // shared by op and op-imm, bit 30 picks sra over srl
  always_comb begin
    case (i_inst.r.funct3)
      3'b000:  alu_f3 = id_ctrl_pkg::ALU_ADD;
      3'b001:  alu_f3 = id_ctrl_pkg::ALU_SLL;
      3'b010:  alu_f3 = id_ctrl_pkg::ALU_SLT;
      3'b011:  alu_f3 = id_ctrl_pkg::ALU_SLTU;
      3'b100:  alu_f3 = id_ctrl_pkg::ALU_XOR;
      3'b101:  alu_f3 = i_inst.r.funct7[5] ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
      3'b110:  alu_f3 = id_ctrl_pkg::ALU_OR;
      default: alu_f3 = id_ctrl_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    o_rs1          = '0;
    o_rs2          = '0;
    o_rd           = '0;
    imm32          = '0;
    o_alu_op       = id_ctrl_pkg::ALU_ADD;
    o_alu_src1_sel = id_ctrl_pkg::SRC1_RS1;
    o_alu_src2_sel = id_ctrl_pkg::SRC2_RS2;
    o_mem_op       = '0;
    bren           = 1'b0;
    jen            = 1'b0;
    jalr           = 1'b0;
    gpr_wen        = 1'b0;
    mem_ren        = 1'b0;
    mem_wen        = 1'b0;
    known          = 1'b1;
    case (i_inst.r.opcode)
      rv_isa_pkg::OPC_OP: begin
        o_rs1    = i_inst.r.rs1;
        o_rs2    = i_inst.r.rs2;
        o_rd     = i_inst.r.rd;
        o_alu_op = (i_inst.r.funct3 == 3'b000 && i_inst.r.funct7[5])
                 ? id_ctrl_pkg::ALU_SUB : alu_f3;
        gpr_wen  = 1'b1;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        o_rs1          = i_inst.i.rs1;
        o_rd           = i_inst.i.rd;
        imm32          = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
        o_alu_op       = alu_f3;                // no subi
        o_alu_src2_sel = id_ctrl_pkg::SRC2_IMM;
        gpr_wen        = 1'b1;
      end
      rv_isa_pkg::OPC_LUI: begin
        o_rd           = i_inst.u.rd;
        imm32          = {i_inst.u.imm_31_12, 12'b0};
        o_alu_op       = id_ctrl_pkg::ALU_COPY2;
        o_alu_src2_sel = id_ctrl_pkg::SRC2_IMM;
        gpr_wen        = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        o_rd           = i_inst.u.rd;
        imm32          = {i_inst.u.imm_31_12, 12'b0};
        o_alu_src1_sel = id_ctrl_pkg::SRC1_PC;
        o_alu_src2_sel = id_ctrl_pkg::SRC2_IMM;
        gpr_wen        = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        o_rd           = i_inst.j.rd;
        imm32          = {{12{i_inst.j.imm_20}}, i_inst.j.imm_19_12, i_inst.j.imm_11,
                          i_inst.j.imm_10_1, 1'b0};
        o_alu_src1_sel = id_ctrl_pkg::SRC1_PC;  // link = pc + 4
        o_alu_src2_sel = id_ctrl_pkg::SRC2_FOUR;
        gpr_wen        = 1'b1;
        jen            = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        o_rs1          = i_inst.i.rs1;
        o_rd           = i_inst.i.rd;
        imm32          = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
        o_alu_src1_sel = id_ctrl_pkg::SRC1_PC;
        o_alu_src2_sel = id_ctrl_pkg::SRC2_FOUR;
        gpr_wen        = 1'b1;
        jen            = 1'b1;
        jalr           = 1'b1;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        o_rs1 = i_inst.b.rs1;
        o_rs2 = i_inst.b.rs2;
        imm32 = {{20{i_inst.b.imm_12}}, i_inst.b.imm_11, i_inst.b.imm_10_5,
                 i_inst.b.imm_4_1, 1'b0};
        bren  = 1'b1;
      end
      rv_isa_pkg::OPC_LOAD: begin
        o_rs1          = i_inst.i.rs1;
        o_rd           = i_inst.i.rd;
        imm32          = {{20{i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
        o_alu_src2_sel = id_ctrl_pkg::SRC2_IMM;  // address = rs1 + imm
        o_mem_op       = i_inst.i.funct3;
        gpr_wen        = 1'b1;
        mem_ren        = 1'b1;
      end
      rv_isa_pkg::OPC_STORE: begin
        o_rs1          = i_inst.s.rs1;
        o_rs2          = i_inst.s.rs2;
        imm32          = {{20{i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
        o_alu_src2_sel = id_ctrl_pkg::SRC2_IMM;
        o_mem_op       = i_inst.s.funct3;
        mem_wen        = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  assign o_imm    = {{(id_ctrl_pkg::XLEN-32){imm32[31]}}, imm32};
  assign o_brfunc = i_inst.b.funct3;

  // nothing fires without a valid instruction
  assign o_bren    = i_valid & bren;
  assign o_jen     = i_valid & jen;
  assign o_jalr    = i_valid & jalr;
  assign o_gpr_wen = i_valid & gpr_wen;
  assign o_mem_ren = i_valid & mem_ren;
  assign o_mem_wen = i_valid & mem_wen;
  assign o_invalid = i_valid & ~known;

endmodule

`default_nettype wire

/* hdl/id_ctrl_pkg.sv */
// widths and codes of the decoded control fields passed on to execute
`default_nettype none

package id_ctrl_pkg;

  localparam int unsigned XLEN        = 64;  // gpr and pc width
  localparam int unsigned GPR_ADDR_WD = 5;
  localparam int unsigned ALU_OP_WD   = 5;
  localparam int unsigned MEM_OP_WD   = 3;   // same code as load/store funct3

  // alu operations
  localparam logic [ALU_OP_WD-1:0] ALU_ADD   = 5'd0;
  localparam logic [ALU_OP_WD-1:0] ALU_SUB   = 5'd1;
  localparam logic [ALU_OP_WD-1:0] ALU_SLL   = 5'd2;
  localparam logic [ALU_OP_WD-1:0] ALU_SLT   = 5'd3;
  localparam logic [ALU_OP_WD-1:0] ALU_SLTU  = 5'd4;
  localparam logic [ALU_OP_WD-1:0] ALU_XOR   = 5'd5;
  localparam logic [ALU_OP_WD-1:0] ALU_SRL   = 5'd6;
  localparam logic [ALU_OP_WD-1:0] ALU_SRA   = 5'd7;
  localparam logic [ALU_OP_WD-1:0] ALU_OR    = 5'd8;
  localparam logic [ALU_OP_WD-1:0] ALU_AND   = 5'd9;
  localparam logic [ALU_OP_WD-1:0] ALU_COPY2 = 5'd10;  // result is operand 2, for lui

  // operand 1 select
  localparam logic SRC1_RS1 = 1'b0;
  localparam logic SRC1_PC  = 1'b1;

  // operand 2 select
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;  // link value pc+4

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
// rv64i instruction formats, major opcodes and branch funct3 codes
`default_nettype none

package rv_isa_pkg;

  localparam int unsigned INST_WD = 32;

  // major opcodes, bits [6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // the six base formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;     // stored below imm_4_1
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, read through whichever format the opcode calls for
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_inst_u;

endpackage

`default_nettype wire
